/* common/matmul_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the 4x4 matmul accelerator, fixed at 32-bit elements
// buf_wr_t carries an 8-bit address, users take the low BUF_AW bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package matmul_pkg;

    localparam int SA_WIDTH    = 4;
    localparam int ROW_BEATS   = 4;
    localparam int BURST_BEATS = 16;
    localparam int ELEM_W      = 32;
    localparam int BUF_AW_MAX  = 8;

    // axi encodings
    localparam logic [2:0] AXI_SIZE_4B    = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef logic [ELEM_W-1:0]                 elem_t;
    typedef logic [31:0]                       addr_t;
    typedef logic [0:0]                        axi_id_t;
    // full 32x32 product plus one bit of headroom
    typedef logic signed [2*ELEM_W:0]          accum_t;
    // element 0 in the low bits
    typedef logic [ROW_BEATS*ELEM_W-1:0]       buf_row_t;
    typedef logic [4:0]                        beat_cnt_t;
    // row-major, index i*SA_WIDTH+j
    typedef accum_t [SA_WIDTH*SA_WIDTH-1:0]    accum_array_t;

    typedef struct packed {
        logic       arvalid;
        axi_id_t    arid;
        addr_t      araddr;
        logic [7:0] arlen;
        logic [2:0] arsize;
        logic [1:0] arburst;
    } axi_ar_t;

    typedef struct packed {
        logic    rvalid;
        axi_id_t rid;
        elem_t   rdata;
        logic    rlast;
    } axi_r_t;

    typedef struct packed {
        logic       awvalid;
        addr_t      awaddr;
        logic [7:0] awlen;
        logic [2:0] awsize;
        logic [1:0] awburst;
    } axi_aw_t;

    typedef struct packed {
        logic       wvalid;
        elem_t      wdata;
        logic [3:0] wstrb;
        logic       wlast;
    } axi_w_t;

    typedef struct packed {
        logic bvalid;
    } axi_b_t;

    typedef struct packed {
        logic                  wren;
        logic [BUF_AW_MAX-1:0] waddr;
        buf_row_t              wdata;
    } buf_wr_t;

    typedef enum logic [3:0] {
        IDLE, ADDR_A, ADDR_B, LOAD, START_MM, WAIT_MM, ADDR_C, WRITE_C, WAIT_B, DONE
    } dma_state_t;

    // prefixed, the job FSM already owns IDLE
    typedef enum logic [1:0] {
        MM_IDLE, MM_READ, MM_MAC, MM_FINISH
    } mm_state_t;

endpackage

/* source/matrix_buffer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one write port, one registered read port, read data one cycle later
// BUF_AW must not exceed the 8-bit write address of buf_wr_t
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module matrix_buffer #(
    parameter int BUF_AW = 6
) (
    input  logic                 clk,
    input  matmul_pkg::buf_wr_t  wr_i,
    input  logic [BUF_AW-1:0]    raddr_i,
    output matmul_pkg::buf_row_t rdata_o
);
    import matmul_pkg::*;

    localparam int DEPTH = 2 ** BUF_AW;

    buf_row_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_i.wren)
            mem[wr_i.waddr[BUF_AW-1:0]] <= wr_i.wdata;
    end

    // read before write when the addresses collide
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* dma_engine/dma_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one job at a time, A on rid 0 and B on rid 1, R beats may interleave
// rresp and bresp are ignored, exactly 16 beats per id are expected
// host start_i/done_o follow a four-phase req/ack handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dma_engine #(
    parameter int BUF_AW = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // host side
    input  matmul_pkg::addr_t        mat_a_addr_i,
    input  matmul_pkg::addr_t        mat_b_addr_i,
    input  matmul_pkg::addr_t        mat_c_addr_i,
    input  logic                     start_i,
    output logic                     done_o,

    // axi master
    output matmul_pkg::axi_ar_t      ar_o,
    input  logic                     arready_i,
    input  matmul_pkg::axi_r_t       r_i,
    output logic                     rready_o,
    output matmul_pkg::axi_aw_t      aw_o,
    input  logic                     awready_i,
    output matmul_pkg::axi_w_t       w_o,
    input  logic                     wready_i,
    input  matmul_pkg::axi_b_t       b_i,
    output logic                     bready_o,

    // buffer write ports
    output matmul_pkg::buf_wr_t      buf_a_wr_o,
    output matmul_pkg::buf_wr_t      buf_b_wr_o,

    // multiply engine
    output logic                     mm_start_o,
    input  logic                     mm_done_i,
    input  matmul_pkg::accum_array_t accum_i
);
    import matmul_pkg::*;

    // index 0 is matrix A, index 1 is matrix B
    localparam int NUM_MAT = 2;

    dma_state_t        state_q;
    dma_state_t        state_d;

    logic              r_fire;
    logic              w_fire;
    logic              load_done;
    logic [1:0]        r_hit;

    beat_cnt_t         cnt_q   [NUM_MAT];
    logic              wren_q  [NUM_MAT];
    logic [BUF_AW-1:0] waddr_q [NUM_MAT];
    buf_row_t          pack_q  [NUM_MAT];
    beat_cnt_t         cnt_c_q;

    assign r_fire   = r_i.rvalid && rready_o;
    assign w_fire   = w_o.wvalid && wready_i;
    assign r_hit[0] = r_fire && (r_i.rid == 1'b0);
    assign r_hit[1] = r_fire && (r_i.rid == 1'b1);

    // true in the cycle of the last row write of the later matrix
    assign load_done = (cnt_q[0] == beat_cnt_t'(BURST_BEATS))
                    && (cnt_q[1] == beat_cnt_t'(BURST_BEATS));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i)
                    state_d = ADDR_A;
            end
            ADDR_A: begin
                if (arready_i)
                    state_d = ADDR_B;
            end
            ADDR_B: begin
                if (arready_i)
                    state_d = LOAD;
            end
            LOAD: begin
                if (load_done)
                    state_d = START_MM;
            end
            START_MM: begin
                state_d = WAIT_MM;
            end
            WAIT_MM: begin
                if (mm_done_i)
                    state_d = ADDR_C;
            end
            ADDR_C: begin
                if (awready_i)
                    state_d = WRITE_C;
            end
            WRITE_C: begin
                if (w_fire && w_o.wlast)
                    state_d = WAIT_B;
            end
            WAIT_B: begin
                if (b_i.bvalid)
                    state_d = DONE;
            end
            DONE: begin
                // hold done until the host drops its request
                if (!start_i)
                    state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_c_q <= '0;
            for (int id = 0; id < NUM_MAT; id++) begin
                cnt_q[id]  <= '0;
                wren_q[id] <= 1'b0;
            end
        end else begin
            state_q <= state_d;
            if (state_q == IDLE)
                cnt_c_q <= '0;
            else if (w_fire)
                cnt_c_q <= cnt_c_q + 1'b1;
            for (int id = 0; id < NUM_MAT; id++) begin
                // row write one cycle after its fourth beat
                wren_q[id] <= r_hit[id] && (cnt_q[id][1:0] == 2'(ROW_BEATS - 1));
                if (state_q == IDLE)
                    cnt_q[id] <= '0;
                else if (r_hit[id])
                    cnt_q[id] <= cnt_q[id] + 1'b1;
            end
        end
    end

    // packing registers, steered by rid
    always_ff @(posedge clk) begin
        for (int id = 0; id < NUM_MAT; id++) begin
            if (r_hit[id]) begin
                pack_q[id][cnt_q[id][1:0]*ELEM_W +: ELEM_W] <= r_i.rdata;
                waddr_q[id] <= BUF_AW'(cnt_q[id] >> 2);
            end
        end
    end

    always_comb begin
        buf_a_wr_o       = '0;
        buf_a_wr_o.wren  = wren_q[0];
        buf_a_wr_o.waddr = BUF_AW_MAX'(waddr_q[0]);
        buf_a_wr_o.wdata = pack_q[0];
        buf_b_wr_o       = '0;
        buf_b_wr_o.wren  = wren_q[1];
        buf_b_wr_o.waddr = BUF_AW_MAX'(waddr_q[1]);
        buf_b_wr_o.wdata = pack_q[1];
    end

    always_comb begin
        ar_o         = '0;
        ar_o.arvalid = (state_q == ADDR_A) || (state_q == ADDR_B);
        ar_o.arid    = (state_q == ADDR_B) ? 1'b1 : 1'b0;
        ar_o.araddr  = (state_q == ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
        ar_o.arlen   = 8'(BURST_BEATS - 1);
        ar_o.arsize  = AXI_SIZE_4B;
        ar_o.arburst = AXI_BURST_INCR;
    end

    always_comb begin
        aw_o         = '0;
        aw_o.awvalid = (state_q == ADDR_C);
        aw_o.awaddr  = mat_c_addr_i;
        aw_o.awlen   = 8'(BURST_BEATS - 1);
        aw_o.awsize  = AXI_SIZE_4B;
        aw_o.awburst = AXI_BURST_INCR;
    end

    // C goes out row-major, low 32 bits of each accumulator
    always_comb begin
        w_o        = '0;
        w_o.wvalid = (state_q == WRITE_C);
        w_o.wdata  = accum_i[cnt_c_q[3:0]][ELEM_W-1:0];
        w_o.wstrb  = '1;
        w_o.wlast  = w_o.wvalid && (cnt_c_q == beat_cnt_t'(BURST_BEATS - 1));
    end

    assign rready_o   = (state_q == LOAD);
    assign bready_o   = (state_q == WAIT_B);
    assign mm_start_o = (state_q == START_MM);
    assign done_o     = (state_q == DONE);

    // write data held while the slave stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        w_o.wvalid && !wready_i |=> w_o.wvalid && $stable(w_o.wdata) && $stable(w_o.wlast));

    // a slave sending extra beats on one id would push a row past the matrix
    assert property (@(posedge clk) disable iff (!rst_n)
        (!buf_a_wr_o.wren || buf_a_wr_o.waddr < SA_WIDTH)
        && (!buf_b_wr_o.wren || buf_b_wr_o.waddr < SA_WIDTH));

endmodule

/* mm_engine/mm_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4x4 signed multiply, one read/MAC pair per (i,k), 33 cycles per job
// accumulators are held stable from mm_done until the next mm_start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mm_engine #(
    parameter int BUF_AW = 6
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mm_start_i,
    output logic                     mm_done_o,
    output logic [BUF_AW-1:0]        a_raddr_o,
    output logic [BUF_AW-1:0]        b_raddr_o,
    input  matmul_pkg::buf_row_t     a_rdata_i,
    input  matmul_pkg::buf_row_t     b_rdata_i,
    output matmul_pkg::accum_array_t accum_o
);
    import matmul_pkg::*;

    mm_state_t                 state_q;
    beat_cnt_t                 step_q;
    accum_array_t              acc_q;

    logic [1:0]                row_i;
    logic [1:0]                col_k;
    logic signed [ELEM_W-1:0]  a_ik;
    logic signed [2*ELEM_W-1:0] prod [SA_WIDTH];

    // step = i*4 + k
    assign row_i = step_q[3:2];
    assign col_k = step_q[1:0];

    assign a_raddr_o = BUF_AW'(row_i);
    assign b_raddr_o = BUF_AW'(col_k);

    // A[i][k] times each element of B row k
    always_comb begin
        a_ik = a_rdata_i[col_k*ELEM_W +: ELEM_W];
        for (int j = 0; j < SA_WIDTH; j++) begin
            prod[j] = a_ik * $signed(b_rdata_i[j*ELEM_W +: ELEM_W]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MM_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MM_IDLE: begin
                    step_q <= '0;
                    if (mm_start_i)
                        state_q <= MM_READ;
                end
                MM_READ: begin
                    state_q <= MM_MAC;
                end
                MM_MAC: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == beat_cnt_t'(BURST_BEATS - 1))
                        state_q <= MM_FINISH;
                    else
                        state_q <= MM_READ;
                end
                default: begin
                    state_q <= MM_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MM_IDLE && mm_start_i) begin
            acc_q <= '0;
        end else if (state_q == MM_MAC) begin
            for (int j = 0; j < SA_WIDTH; j++) begin
                // sign-extend the product into the 65-bit accumulator
                acc_q[{row_i, 2'(j)}] <= acc_q[{row_i, 2'(j)}]
                                       + {prod[j][2*ELEM_W-1], prod[j]};
            end
        end
    end

    assign accum_o   = acc_q;
    assign mm_done_o = (state_q == MM_FINISH);

    // the job FSM must wait for done before starting again
    assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_i |-> state_q == MM_IDLE);

endmodule

/* source/matmul_accel_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4x4 int32 matmul accelerator, AXI master for A, B reads and C write
// only BUF_AW is tunable, all other sizes are fixed in matmul_pkg
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module matmul_accel_top #(
    parameter int BUF_AW = 6
) (
    input  logic                clk,
    input  logic                rst_n,

    // host configuration and handshake
    input  matmul_pkg::addr_t   mat_a_addr_i,
    input  matmul_pkg::addr_t   mat_b_addr_i,
    input  matmul_pkg::addr_t   mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,

    // axi master
    output matmul_pkg::axi_ar_t ar_o,
    input  logic                arready_i,
    input  matmul_pkg::axi_r_t  r_i,
    output logic                rready_o,
    output matmul_pkg::axi_aw_t aw_o,
    input  logic                awready_i,
    output matmul_pkg::axi_w_t  w_o,
    input  logic                wready_i,
    input  matmul_pkg::axi_b_t  b_i,
    output logic                bready_o
);
    import matmul_pkg::*;

    buf_wr_t           buf_a_wr;
    buf_wr_t           buf_b_wr;
    logic [BUF_AW-1:0] a_raddr;
    logic [BUF_AW-1:0] b_raddr;
    buf_row_t          a_rdata;
    buf_row_t          b_rdata;
    logic              mm_start;
    logic              mm_done;
    accum_array_t      accum;

    dma_engine #(
        .BUF_AW (BUF_AW)
    ) dma_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .ar_o         (ar_o),
        .arready_i    (arready_i),
        .r_i          (r_i),
        .rready_o     (rready_o),
        .aw_o         (aw_o),
        .awready_i    (awready_i),
        .w_o          (w_o),
        .wready_i     (wready_i),
        .b_i          (b_i),
        .bready_o     (bready_o),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    matrix_buffer #(
        .BUF_AW (BUF_AW)
    ) buf_a (
        .clk     (clk),
        .wr_i    (buf_a_wr),
        .raddr_i (a_raddr),
        .rdata_o (a_rdata)
    );

    matrix_buffer #(
        .BUF_AW (BUF_AW)
    ) buf_b (
        .clk     (clk),
        .wr_i    (buf_b_wr),
        .raddr_i (b_raddr),
        .rdata_o (b_rdata)
    );

    mm_engine #(
        .BUF_AW (BUF_AW)
    ) mm_engine_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mm_start_i (mm_start),
        .mm_done_o  (mm_done),
        .a_raddr_o  (a_raddr),
        .b_raddr_o  (b_raddr),
        .a_rdata_i  (a_rdata),
        .b_rdata_i  (b_rdata),
        .accum_o    (accum)
    );

endmodule

/* tb/axi_mem_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-addressed AXI slave of 256 words picked by byte address bits 9:2
// one read burst per id and one write burst at a time with no error responses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axi_mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  int unsigned         r_stall_pct_i,
    input  int unsigned         w_stall_pct_i,
    input  logic                interleave_i,
    input  logic                load_en_i,
    input  matmul_pkg::addr_t   load_addr_i,
    input  matmul_pkg::elem_t   load_data_i,
    input  matmul_pkg::axi_ar_t ar_i,
    output logic                arready_o,
    output matmul_pkg::axi_r_t  r_o,
    input  logic                rready_i,
    input  matmul_pkg::axi_aw_t aw_i,
    output logic                awready_o,
    input  matmul_pkg::axi_w_t  w_i,
    output logic                wready_o,
    output matmul_pkg::axi_b_t  b_o,
    input  logic                bready_i
);
    import matmul_pkg::*;

    elem_t      mem [256];
    logic [7:0] rd_ptr [2];
    beat_cnt_t  rd_left [2];
    logic       last_id;
    logic       aw_active;
    logic [7:0] wr_ptr;
    beat_cnt_t  wr_beat;
    logic       pick;
    logic       pick_ok;

    // last two AR requests with the newer one in index 1
    addr_t      ar_hist_addr [2];
    axi_id_t    ar_hist_id [2];
    logic [7:0] ar_hist_len [2];
    logic [2:0] ar_hist_size [2];
    logic [1:0] ar_hist_burst [2];
    addr_t      aw_last_addr;
    logic [7:0] aw_last_len;
    logic [2:0] aw_last_size;
    logic [1:0] aw_last_burst;
    beat_cnt_t  wlast_beat;
    int         wlast_count;
    int         wstrb_bad_count;
    int         b_count;

    assign arready_o = 1'b1;
    assign awready_o = !aw_active && !b_o.bvalid;

    // next read id alternates between ids when interleaving
    always_comb begin
        pick_ok = (rd_left[0] != '0) || (rd_left[1] != '0);
        if (interleave_i && rd_left[!last_id] != '0)
            pick = !last_id;
        else if (rd_left[0] != '0)
            pick = 1'b0;
        else
            pick = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            r_o             <= '0;
            b_o             <= '0;
            rd_left[0]      <= '0;
            rd_left[1]      <= '0;
            last_id         <= 1'b1;
            aw_active       <= 1'b0;
            wready_o        <= 1'b0;
            wlast_count     <= 0;
            wstrb_bad_count <= 0;
            b_count         <= 0;
        end else begin
            if (load_en_i)
                mem[load_addr_i[9:2]] <= load_data_i;
            if (ar_i.arvalid) begin
                rd_ptr[ar_i.arid]  <= ar_i.araddr[9:2];
                rd_left[ar_i.arid] <= beat_cnt_t'(ar_i.arlen) + beat_cnt_t'(1);
                ar_hist_addr[0]    <= ar_hist_addr[1];
                ar_hist_id[0]      <= ar_hist_id[1];
                ar_hist_len[0]     <= ar_hist_len[1];
                ar_hist_size[0]    <= ar_hist_size[1];
                ar_hist_burst[0]   <= ar_hist_burst[1];
                ar_hist_addr[1]    <= ar_i.araddr;
                ar_hist_id[1]      <= ar_i.arid;
                ar_hist_len[1]     <= ar_i.arlen;
                ar_hist_size[1]    <= ar_i.arsize;
                ar_hist_burst[1]   <= ar_i.arburst;
            end
            // a presented beat holds until the master takes it
            if (!r_o.rvalid || rready_i) begin
                if (pick_ok && $urandom_range(99) >= r_stall_pct_i) begin
                    r_o.rvalid    <= 1'b1;
                    r_o.rid       <= pick;
                    r_o.rdata     <= mem[rd_ptr[pick]];
                    r_o.rlast     <= (rd_left[pick] == beat_cnt_t'(1));
                    rd_ptr[pick]  <= rd_ptr[pick] + 8'd1;
                    rd_left[pick] <= rd_left[pick] - beat_cnt_t'(1);
                    last_id       <= pick;
                end else begin
                    r_o.rvalid <= 1'b0;
                end
            end
            if (aw_i.awvalid && awready_o) begin
                aw_active     <= 1'b1;
                wr_ptr        <= aw_i.awaddr[9:2];
                wr_beat       <= '0;
                aw_last_addr  <= aw_i.awaddr;
                aw_last_len   <= aw_i.awlen;
                aw_last_size  <= aw_i.awsize;
                aw_last_burst <= aw_i.awburst;
            end
            if (w_i.wvalid && wready_o) begin
                mem[wr_ptr] <= w_i.wdata;
                wr_ptr      <= wr_ptr + 8'd1;
                wr_beat     <= wr_beat + beat_cnt_t'(1);
                if (w_i.wstrb != 4'hf)
                    wstrb_bad_count <= wstrb_bad_count + 1;
                if (w_i.wlast) begin
                    wlast_count <= wlast_count + 1;
                    wlast_beat  <= wr_beat + beat_cnt_t'(1);
                    aw_active   <= 1'b0;
                    b_o.bvalid  <= 1'b1;
                end
            end
            wready_o <= aw_active && !(w_i.wvalid && wready_o && w_i.wlast)
                     && ($urandom_range(99) >= w_stall_pct_i);
            if (b_o.bvalid && bready_i) begin
                b_o.bvalid <= 1'b0;
                b_count    <= b_count + 1;
            end
        end
    end

endmodule

/* tb/tb_matmul_accel_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests of the matmul accelerator against an AXI memory model
// all matrices live below byte address 0x400 of the model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_matmul_accel_top;
    import matmul_pkg::*;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;
    localparam int JOB_TIMEOUT     = 1000;

    logic        clk;
    logic        rst_n;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    logic        start;
    logic        done;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    axi_aw_t     aw;
    logic        awready;
    axi_w_t      w;
    logic        wready;
    axi_b_t      b;
    logic        bready;
    int unsigned r_stall_pct;
    int unsigned w_stall_pct;
    logic        interleave;
    logic        load_en;
    addr_t       load_addr;
    elem_t       load_data;

    elem_t mat_a [16];
    elem_t mat_b [16];
    elem_t exp_c [16];
    elem_t first_c [16];
    int    errors;
    int    tests_run;
    int    tests_failed;

    matmul_accel_top #(
        .BUF_AW (6)
    ) matmul_accel_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .start_i      (start),
        .done_o       (done),
        .ar_o         (ar),
        .arready_i    (arready),
        .r_i          (r),
        .rready_o     (rready),
        .aw_o         (aw),
        .awready_i    (awready),
        .w_o          (w),
        .wready_i     (wready),
        .b_i          (b),
        .bready_o     (bready)
    );

    axi_mem_model axi_mem_model_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .r_stall_pct_i (r_stall_pct),
        .w_stall_pct_i (w_stall_pct),
        .interleave_i  (interleave),
        .load_en_i     (load_en),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .ar_i          (ar),
        .arready_o     (arready),
        .r_o           (r),
        .rready_i      (rready),
        .aw_i          (aw),
        .awready_o     (awready),
        .w_i           (w),
        .wready_o      (wready),
        .b_o           (b),
        .bready_i      (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Simulation failed");
        $finish;
    end

    task automatic note_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic compare_elem(input elem_t got, input elem_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic load_word(input addr_t addr, input elem_t data);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
    endtask

    // C region gets a pattern of its own addresses so stale data shows
    task automatic load_job(input addr_t a_base, input addr_t b_base, input addr_t c_base);
        for (int n = 0; n < 16; n++) begin
            load_word(a_base + addr_t'(4 * n), mat_a[n]);
            load_word(b_base + addr_t'(4 * n), mat_b[n]);
            load_word(c_base + addr_t'(4 * n), (c_base + addr_t'(4 * n)) ^ 32'h5a5a_0000);
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic random_matrices();
        for (int n = 0; n < 16; n++) begin
            mat_a[n] = $urandom();
            mat_b[n] = $urandom();
        end
    endtask

    // row-major reference product truncated to 32 bits
    task automatic compute_expected();
        elem_t sum;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                sum = '0;
                for (int k = 0; k < 4; k++)
                    sum = sum + mat_a[i * 4 + k] * mat_b[k * 4 + j];
                exp_c[i * 4 + j] = sum;
            end
        end
    endtask

    task automatic run_job(input addr_t a_base, input addr_t b_base, input addr_t c_base);
        int b_before;
        int cycles;
        b_before = axi_mem_model_i.b_count;
        if (done !== 1'b0)
            note_error("done_o was high before the job started");
        @(negedge clk);
        a_addr = a_base;
        b_addr = b_base;
        c_addr = c_base;
        start  = 1'b1;
        cycles = 0;
        while (done !== 1'b1 && cycles < JOB_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1)
            note_error("done_o never rose after start_i");
        else if (axi_mem_model_i.b_count == b_before)
            note_error("done_o rose before the write response");
        repeat (3) begin
            @(negedge clk);
            if (done !== 1'b1)
                note_error("done_o dropped while start_i was still high");
        end
        start = 1'b0;
        @(negedge clk);
        if (done !== 1'b0)
            note_error("done_o stayed high after start_i dropped");
    endtask

    task automatic check_result(input addr_t c_base, input string tag);
        for (int n = 0; n < 16; n++)
            compare_elem(axi_mem_model_i.mem[8'((c_base >> 2) + addr_t'(n))], exp_c[n],
                         $sformatf("%s C[%0d][%0d]", tag, n / 4, n % 4));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic test_identity();
        int e0;
        e0 = errors;
        for (int n = 0; n < 16; n++) begin
            mat_a[n] = $urandom();
            mat_b[n] = (n / 4 == n % 4) ? 32'd1 : 32'd0;
            exp_c[n] = mat_a[n];
        end
        load_job(32'h000, 32'h040, 32'h080);
        run_job(32'h000, 32'h040, 32'h080);
        check_result(32'h080, "identity");
        finish_test("identity B", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = errors;
        random_matrices();
        compute_expected();
        load_job(32'h100, 32'h140, 32'h180);
        run_job(32'h100, 32'h140, 32'h180);
        check_result(32'h180, "random");
        finish_test("random signed", e0);
    endtask

    task automatic test_interleave();
        int e0;
        e0 = errors;
        interleave  = 1'b1;
        r_stall_pct = 30;
        random_matrices();
        compute_expected();
        load_job(32'h1c0, 32'h200, 32'h240);
        run_job(32'h1c0, 32'h200, 32'h240);
        check_result(32'h240, "interleave");
        interleave  = 1'b0;
        r_stall_pct = 0;
        finish_test("interleaved R with gaps", e0);
    endtask

    task automatic test_wstall();
        int e0;
        int wl_before;
        e0 = errors;
        w_stall_pct = 40;
        random_matrices();
        compute_expected();
        load_job(32'h280, 32'h2c0, 32'h300);
        wl_before = axi_mem_model_i.wlast_count;
        run_job(32'h280, 32'h2c0, 32'h300);
        check_result(32'h300, "wstall");
        compare_elem(elem_t'(axi_mem_model_i.wlast_count - wl_before), 32'd1, "wlast count");
        compare_elem(elem_t'(axi_mem_model_i.wlast_beat), 32'd16, "wlast beat");
        w_stall_pct = 0;
        finish_test("wready stalls", e0);
    endtask

    task automatic test_addressing();
        int e0;
        e0 = errors;
        random_matrices();
        compute_expected();
        // A placed above B on purpose
        load_job(32'h2c0, 32'h200, 32'h340);
        run_job(32'h2c0, 32'h200, 32'h340);
        compare_addr(axi_mem_model_i.ar_hist_addr[0], 32'h2c0, "first araddr");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_id[0]), 32'd0, "first arid");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_len[0]), 32'd15, "first arlen");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_size[0]), 32'd2, "first arsize");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_burst[0]), 32'd1, "first arburst");
        compare_addr(axi_mem_model_i.ar_hist_addr[1], 32'h200, "second araddr");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_id[1]), 32'd1, "second arid");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_len[1]), 32'd15, "second arlen");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_size[1]), 32'd2, "second arsize");
        compare_elem(elem_t'(axi_mem_model_i.ar_hist_burst[1]), 32'd1, "second arburst");
        compare_addr(axi_mem_model_i.aw_last_addr, 32'h340, "awaddr");
        compare_elem(elem_t'(axi_mem_model_i.aw_last_len), 32'd15, "awlen");
        compare_elem(elem_t'(axi_mem_model_i.aw_last_size), 32'd2, "awsize");
        compare_elem(elem_t'(axi_mem_model_i.aw_last_burst), 32'd1, "awburst");
        compare_elem(elem_t'(axi_mem_model_i.wstrb_bad_count), 32'd0, "partial wstrb beats");
        check_result(32'h340, "addressing");
        finish_test("AXI addressing", e0);
    endtask

    task automatic test_back_to_back();
        int e0;
        e0 = errors;
        random_matrices();
        compute_expected();
        load_job(32'h000, 32'h040, 32'h080);
        for (int n = 0; n < 16; n++)
            first_c[n] = exp_c[n];
        random_matrices();
        compute_expected();
        load_job(32'h300, 32'h380, 32'h3c0);
        run_job(32'h000, 32'h040, 32'h080);
        for (int n = 0; n < 16; n++)
            compare_elem(axi_mem_model_i.mem[8'(32 + n)], first_c[n],
                         $sformatf("first job C[%0d][%0d]", n / 4, n % 4));
        run_job(32'h300, 32'h380, 32'h3c0);
        check_result(32'h3c0, "second job");
        finish_test("back-to-back handshake", e0);
    endtask

    initial begin
        void'($urandom(19499));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        start        = 1'b0;
        a_addr       = '0;
        b_addr       = '0;
        c_addr       = '0;
        r_stall_pct  = 0;
        w_stall_pct  = 0;
        interleave   = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (done !== 1'b0)
            note_error("done_o was not low after reset");

        test_identity();
        test_random();
        test_interleave();
        test_wstall();
        test_addressing();
        test_back_to_back();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* compile.f */
common/matmul_pkg.sv
source/matrix_buffer.sv
dma_engine/dma_engine.sv
mm_engine/mm_engine.sv
source/matmul_accel_top.sv
tb/axi_mem_model.sv
tb/tb_matmul_accel_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run, the result is taken from the printed output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_matmul_accel_top \
    -f compile.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim) ; printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed" && exit 0 || exit 1
